// ==== src/csr_pkg.sv ====
`default_nettype none

package csr_pkg;

   // ------------------------------------------------------------
   // widths
   // ------------------------------------------------------------
   localparam int XLEN   = 32;
   localparam int CSR_AW = 12;

   // access field value that marks a read-only csr number
   localparam logic [1:0] CSR_ACC_RO = 2'b11;

   // ------------------------------------------------------------
   // csr numbers
   // ------------------------------------------------------------
   // machine trap setup and handling
   localparam logic [CSR_AW-1:0] CSR_MSTATUS       = 12'h300;
   localparam logic [CSR_AW-1:0] CSR_MISA          = 12'h301;
   localparam logic [CSR_AW-1:0] CSR_MIE           = 12'h304;
   localparam logic [CSR_AW-1:0] CSR_MTVEC         = 12'h305;
   localparam logic [CSR_AW-1:0] CSR_MCOUNTEREN    = 12'h306;
   localparam logic [CSR_AW-1:0] CSR_MCOUNTINHIBIT = 12'h320;
   localparam logic [CSR_AW-1:0] CSR_MSCRATCH      = 12'h340;
   localparam logic [CSR_AW-1:0] CSR_MEPC          = 12'h341;
   localparam logic [CSR_AW-1:0] CSR_MCAUSE        = 12'h342;
   localparam logic [CSR_AW-1:0] CSR_MTVAL         = 12'h343;

   // machine counters, low and high halves
   localparam logic [CSR_AW-1:0] CSR_MCYCLE        = 12'hB00;
   localparam logic [CSR_AW-1:0] CSR_MCYCLEH       = 12'hB80;
   localparam logic [CSR_AW-1:0] CSR_MINSTRET      = 12'hB02;
   localparam logic [CSR_AW-1:0] CSR_MINSTRETH     = 12'hB82;

   // user read-only aliases of the counters and the timer
   localparam logic [CSR_AW-1:0] CSR_CYCLE         = 12'hC00;
   localparam logic [CSR_AW-1:0] CSR_TIME          = 12'hC01;
   localparam logic [CSR_AW-1:0] CSR_INSTRET       = 12'hC02;
   localparam logic [CSR_AW-1:0] CSR_CYCLEH        = 12'hC80;
   localparam logic [CSR_AW-1:0] CSR_TIMEH         = 12'hC81;
   localparam logic [CSR_AW-1:0] CSR_INSTRETH      = 12'hC82;

   // machine information, read-only
   localparam logic [CSR_AW-1:0] CSR_MVENDORID     = 12'hF11;
   localparam logic [CSR_AW-1:0] CSR_MARCHID       = 12'hF12;
   localparam logic [CSR_AW-1:0] CSR_MIMPID        = 12'hF13;
   localparam logic [CSR_AW-1:0] CSR_MHARTID       = 12'hF14;

   // ------------------------------------------------------------
   // identification and isa values
   // ------------------------------------------------------------
   localparam logic [XLEN-1:0] MVENDORID_VAL = 32'h0000_0000;
   localparam logic [XLEN-1:0] MARCHID_VAL   = 32'h0000_0001;
   localparam logic [XLEN-1:0] MIMPID_VAL    = 32'h0000_0100;
   localparam logic [XLEN-1:0] MHARTID_VAL   = 32'h0000_0000;
   // mxl=1 (rv32), I bit 8, M bit 12, U bit 20
   localparam logic [XLEN-1:0] MISA_VAL      = 32'h4010_1100;

   // ------------------------------------------------------------
   // warl write masks and reset values
   // ------------------------------------------------------------
   // 32-bit instruction alignment only
   localparam logic [XLEN-1:0] MEPC_WMASK    = 32'hFFFF_FFFC;
   // mode is direct or vectored, bit 1 stays zero
   localparam logic [XLEN-1:0] MTVEC_WMASK   = 32'hFFFF_FFFD;
   // mpp 12:11, mpie 7, mie 3
   localparam logic [XLEN-1:0] MSTATUS_WMASK = 32'h0000_1888;
   // mpp comes out of reset as machine mode
   localparam logic [XLEN-1:0] MSTATUS_RST   = 32'h0000_1800;

   // ------------------------------------------------------------
   // types
   // ------------------------------------------------------------
   typedef enum logic [1:0] {
      U_MODE = 2'd0,
      M_MODE = 2'd3
   } priv_mode_t;

   // csr number split the way the privileged spec lays it out
   typedef struct packed {
      logic [1:0] access;
      logic [1:0] priv;
      logic [7:0] index;
   } csr_addr_fld_t;

   // matched whole for register select, split for ro/priv checks
   typedef union packed {
      logic [CSR_AW-1:0] value;
      csr_addr_fld_t     fld;
   } csr_addr_u;

   // approved write request
   typedef struct packed {
      logic            en;
      csr_addr_u       addr;
      logic [XLEN-1:0] data;
   } csr_wr_t;

   typedef struct packed {
      logic [XLEN-1:0] mstatus;
      logic [XLEN-1:0] mie;
      logic [XLEN-1:0] mtvec;
      logic [XLEN-1:0] mcounteren;
      logic [XLEN-1:0] mcountinhibit;
      logic [XLEN-1:0] mscratch;
      logic [XLEN-1:0] mepc;
      logic [XLEN-1:0] mcause;
      logic [XLEN-1:0] mtval;
   } mregs_t;

   typedef struct packed {
      logic [2*XLEN-1:0] mcycle;
      logic [2*XLEN-1:0] minstret;
   } cntr_t;

endpackage

`default_nettype wire

// ==== src/csr_apb_slave.sv ====
`default_nettype none

module csr_apb_slave import csr_pkg::*;
(
   input  logic            clk,
   input  logic            arst_n,

   // apb slave side
   input  logic            psel,
   input  logic            penable,
   input  logic            pwrite,
   input  logic [13:0]     paddr,
   input  logic [XLEN-1:0] pwdata,
   output logic [XLEN-1:0] prdata,
   output logic            pready,
   output logic            pslverr,

   // decode side
   output csr_addr_u       csr_addr,
   input  logic [XLEN-1:0] rdata,
   input  logic            access_ok,

   // write request to registers and counters
   output csr_wr_t         wr
);

   // ------------------------------------------------------------
   // access phase tracking
   // ------------------------------------------------------------
   logic access_ph;
   logic access_q;
   logic access_new;
   logic wr_ok;

   // psel and penable both high is the access phase
   assign access_ph = psel & penable;

   // high in the cycle after any access phase
   // a held access without a new setup phase is not taken again
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         access_q <= 1'b0;
      else
         access_q <= access_ph;
   end

   // first cycle of an access phase only
   assign access_new = access_ph & ~access_q;

   // ------------------------------------------------------------
   // csr number and response
   // ------------------------------------------------------------
   // word addressed, csr number sits above the byte offset
   assign csr_addr.value = paddr[13:2];

   // no wait states
   assign pready  = access_new;
   // refused: not available to this mode, or write to read-only
   assign pslverr = access_new & ~access_ok;
   // zero on a refused access
   assign prdata  = (access_new & access_ok) ? rdata : '0;

   // ------------------------------------------------------------
   // write request
   // ------------------------------------------------------------
   assign wr_ok = access_new & pwrite & access_ok;

   // valid only in the accepted access cycle
   assign wr.en   = wr_ok;
   assign wr.addr = csr_addr;
   assign wr.data = pwdata;

endmodule

`default_nettype wire

// ==== src/csr_decode.sv ====
`default_nettype none

module csr_decode import csr_pkg::*;
(
   input  csr_addr_u         csr_addr,
   input  logic              write,
   input  priv_mode_t        priv_mode,
   input  mregs_t            mregs,
   input  cntr_t             cntr,
   input  logic [2*XLEN-1:0] mtime,
   output logic [XLEN-1:0]   rdata,
   output logic              access_ok
);

   logic [XLEN-1:0] value;
   logic            known;
   logic            user_cntr;
   logic            cntr_en;
   logic            priv_ok;
   logic            ro_ok;
   logic [1:0]      mode_lvl;

   // ------------------------------------------------------------
   // number to value decode
   // ------------------------------------------------------------
   always_comb
   begin
      // unknown numbers read as zero
      known     = 1'b1;
      user_cntr = 1'b0;
      value     = '0;

      case (csr_addr.value)
         // machine trap setup
         CSR_MSTATUS:
            value = mregs.mstatus;
         CSR_MISA:
            value = MISA_VAL;
         CSR_MIE:
            value = mregs.mie;
         CSR_MTVEC:
            value = mregs.mtvec;
         CSR_MCOUNTEREN:
            value = mregs.mcounteren;
         CSR_MCOUNTINHIBIT:
            value = mregs.mcountinhibit;

         // machine trap handling
         CSR_MSCRATCH:
            value = mregs.mscratch;
         // low bits never read back, 32-bit alignment
         CSR_MEPC:
            value = mregs.mepc & MEPC_WMASK;
         CSR_MCAUSE:
            value = mregs.mcause;
         CSR_MTVAL:
            value = mregs.mtval;

         // machine counters
         CSR_MCYCLE:
            value = cntr.mcycle[XLEN-1:0];
         CSR_MCYCLEH:
            value = cntr.mcycle[2*XLEN-1:XLEN];
         CSR_MINSTRET:
            value = cntr.minstret[XLEN-1:0];
         CSR_MINSTRETH:
            value = cntr.minstret[2*XLEN-1:XLEN];

         // machine information
         CSR_MVENDORID:
            value = MVENDORID_VAL;
         CSR_MARCHID:
            value = MARCHID_VAL;
         CSR_MIMPID:
            value = MIMPID_VAL;
         CSR_MHARTID:
            value = MHARTID_VAL;

         // user aliases, gated by mcounteren below
         CSR_CYCLE:
         begin
            user_cntr = 1'b1;
            value     = cntr.mcycle[XLEN-1:0];
         end
         CSR_TIME:
         begin
            user_cntr = 1'b1;
            value     = mtime[XLEN-1:0];
         end
         CSR_INSTRET:
         begin
            user_cntr = 1'b1;
            value     = cntr.minstret[XLEN-1:0];
         end
         CSR_CYCLEH:
         begin
            user_cntr = 1'b1;
            value     = cntr.mcycle[2*XLEN-1:XLEN];
         end
         CSR_TIMEH:
         begin
            user_cntr = 1'b1;
            value     = mtime[2*XLEN-1:XLEN];
         end
         CSR_INSTRETH:
         begin
            user_cntr = 1'b1;
            value     = cntr.minstret[2*XLEN-1:XLEN];
         end

         default:
            known = 1'b0;
      endcase
   end

   // ------------------------------------------------------------
   // availability
   // ------------------------------------------------------------
   assign mode_lvl = priv_mode;

   // machine mode sees every counter
   // user mode needs the mcounteren bit picked by the low five bits
   assign cntr_en = (priv_mode == M_MODE) | mregs.mcounteren[csr_addr.fld.index[4:0]];

   // others: privilege field must not exceed the current mode
   assign priv_ok = user_cntr ? cntr_en : (csr_addr.fld.priv <= mode_lvl);

   // access bits 11 mark read-only numbers
   assign ro_ok = ~(write & (csr_addr.fld.access == CSR_ACC_RO));

   assign access_ok = known & priv_ok & ro_ok;
   assign rdata     = access_ok ? value : '0;

endmodule

`default_nettype wire

// ==== src/csr_machine_regs.sv ====
`default_nettype none

module csr_machine_regs import csr_pkg::*;
(
   input  logic    clk,
   input  logic    arst_n,
   input  csr_wr_t wr,
   output mregs_t  mregs
);

   // ------------------------------------------------------------
   // machine read-write csrs
   // ------------------------------------------------------------
   // misa and the id values are constants in the decode
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         // mpp starts in machine mode, everything else clear
         mregs.mstatus       <= MSTATUS_RST;
         mregs.mie           <= '0;
         mregs.mtvec         <= '0;
         mregs.mcounteren    <= '0;
         mregs.mcountinhibit <= '0;
         mregs.mscratch      <= '0;
         mregs.mepc          <= '0;
         mregs.mcause        <= '0;
         mregs.mtval         <= '0;
      end
      else if (wr.en)
      begin
         // request is already approved by the decode
         case (wr.addr.value)
            // only mie, mpie and mpp are implemented
            CSR_MSTATUS:
               mregs.mstatus <= wr.data & MSTATUS_WMASK;
            CSR_MIE:
               mregs.mie <= wr.data;
            // mode bit 1 is reserved, held at zero
            CSR_MTVEC:
               mregs.mtvec <= wr.data & MTVEC_WMASK;
            // bit n lets user mode read counter n
            CSR_MCOUNTEREN:
               mregs.mcounteren <= wr.data;
            // bit 0 stops mcycle, bit 2 stops minstret
            CSR_MCOUNTINHIBIT:
               mregs.mcountinhibit <= wr.data;
            CSR_MSCRATCH:
               mregs.mscratch <= wr.data;
            // ialign is fixed at 32
            CSR_MEPC:
               mregs.mepc <= wr.data & MEPC_WMASK;
            CSR_MCAUSE:
               mregs.mcause <= wr.data;
            CSR_MTVAL:
               mregs.mtval <= wr.data;
            default:
            begin
               // counters and read-only numbers live elsewhere
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== src/csr_counters.sv ====
`default_nettype none

module csr_counters import csr_pkg::*;
(
   input  logic            clk,
   input  logic            arst_n,
   input  csr_wr_t         wr,
   input  logic            instr_retired,
   input  logic [XLEN-1:0] mcountinhibit,
   output cntr_t           cntr
);

   logic cyc_ph;
   logic cyc_wr_lo;
   logic cyc_wr_hi;
   logic ret_wr_lo;
   logic ret_wr_hi;
   logic cyc_inc;
   logic ret_inc;

   // ------------------------------------------------------------
   // software writes
   // ------------------------------------------------------------
   assign cyc_wr_lo = wr.en & (wr.addr.value == CSR_MCYCLE);
   assign cyc_wr_hi = wr.en & (wr.addr.value == CSR_MCYCLEH);
   assign ret_wr_lo = wr.en & (wr.addr.value == CSR_MINSTRET);
   assign ret_wr_hi = wr.en & (wr.addr.value == CSR_MINSTRETH);

   // ------------------------------------------------------------
   // increment enables
   // ------------------------------------------------------------
   // mcycle ticks on every second clock
   assign cyc_inc = cyc_ph & ~mcountinhibit[0];
   // one per retired instruction
   assign ret_inc = instr_retired & ~mcountinhibit[2];

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         cyc_ph        <= 1'b0;
         cntr.mcycle   <= '0;
         cntr.minstret <= '0;
      end
      else
      begin
         cyc_ph <= ~cyc_ph;

         // a write to either half wins over the increment
         if (cyc_wr_lo)
            cntr.mcycle[XLEN-1:0] <= wr.data;
         else if (cyc_wr_hi)
            cntr.mcycle[2*XLEN-1:XLEN] <= wr.data;
         else if (cyc_inc)
            cntr.mcycle <= cntr.mcycle + 64'd1;

         if (ret_wr_lo)
            cntr.minstret[XLEN-1:0] <= wr.data;
         else if (ret_wr_hi)
            cntr.minstret[2*XLEN-1:XLEN] <= wr.data;
         else if (ret_inc)
            cntr.minstret <= cntr.minstret + 64'd1;
      end
   end

endmodule

`default_nettype wire

// ==== src/csr_unit.sv ====
`default_nettype none

module csr_unit import csr_pkg::*;
(
   input  logic              clk,
   input  logic              arst_n,

   // apb slave port, csr number on paddr 13:2
   input  logic              psel,
   input  logic              penable,
   input  logic              pwrite,
   input  logic [13:0]       paddr,
   input  logic [XLEN-1:0]   pwdata,
   output logic [XLEN-1:0]   prdata,
   output logic              pready,
   output logic              pslverr,

   // core side
   input  priv_mode_t        priv_mode,
   input  logic [2*XLEN-1:0] mtime,
   input  logic              instr_retired
);

   // ------------------------------------------------------------
   // internal nets
   // ------------------------------------------------------------
   csr_addr_u       csr_addr;
   logic [XLEN-1:0] rdata;
   logic            access_ok;
   csr_wr_t         wr;
   mregs_t          mregs;
   cntr_t           cntr;

   // apb handshake and write approval
   csr_apb_slave u_apb (
      .clk       (clk),
      .arst_n    (arst_n),
      .psel      (psel),
      .penable   (penable),
      .pwrite    (pwrite),
      .paddr     (paddr),
      .pwdata    (pwdata),
      .prdata    (prdata),
      .pready    (pready),
      .pslverr   (pslverr),
      .csr_addr  (csr_addr),
      .rdata     (rdata),
      .access_ok (access_ok),
      .wr        (wr)
   );

   // availability and read mux
   csr_decode u_decode (
      .csr_addr  (csr_addr),
      .write     (pwrite),
      .priv_mode (priv_mode),
      .mregs     (mregs),
      .cntr      (cntr),
      .mtime     (mtime),
      .rdata     (rdata),
      .access_ok (access_ok)
   );

   csr_machine_regs u_mregs (
      .clk    (clk),
      .arst_n (arst_n),
      .wr     (wr),
      .mregs  (mregs)
   );

   // counters take their inhibit bits straight from mcountinhibit
   csr_counters u_cntr (
      .clk           (clk),
      .arst_n        (arst_n),
      .wr            (wr),
      .instr_retired (instr_retired),
      .mcountinhibit (mregs.mcountinhibit),
      .cntr          (cntr)
   );

endmodule

`default_nettype wire

// ==== sim/tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen
(
   output logic clk,
   output logic arst_n
);

   timeunit 1ns;
   timeprecision 1ps;

   // 100 ns period
   localparam int HALF_PERIOD  = 50;
   localparam int RESET_CYCLES = 16;

   initial
   begin
      clk = 1'b0;
      forever
         #(HALF_PERIOD) clk = ~clk;
   end

   // release on a falling edge, away from the register updates
   initial
   begin
      arst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;
   end

endmodule

`default_nettype wire

// ==== sim/csr_unit_props.sv ====
`default_nettype none

module csr_unit_props
(
   input logic clk,
   input logic arst_n,
   input logic psel,
   input logic penable,
   input logic pready,
   input logic pslverr
);

   timeunit 1ns;
   timeprecision 1ps;

   // ------------------------------------------------------------
   // apb response rules
   // ------------------------------------------------------------
   // the slave only answers inside an access phase
   ready_in_access: assert property (@(posedge clk) disable iff (!arst_n)
      pready |-> (psel && penable))
      else $error("pready high outside an access phase");

   // an error response is always a completed transfer
   err_with_ready: assert property (@(posedge clk) disable iff (!arst_n)
      pslverr |-> pready)
      else $error("pslverr high without pready");

   // setup phase never completes
   no_ready_in_setup: assert property (@(posedge clk) disable iff (!arst_n)
      (psel && !penable) |-> !pready)
      else $error("pready high in a setup phase");

endmodule

// attached to every apb slave instance
bind csr_apb_slave csr_unit_props props0 (
   .clk     (clk),
   .arst_n  (arst_n),
   .psel    (psel),
   .penable (penable),
   .pready  (pready),
   .pslverr (pslverr)
);

`default_nettype wire

// ==== sim/tb_csr_unit.sv ====
`default_nettype none

module tb_csr_unit import csr_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   // ------------------------------------------------------------
   // limits and expected masks
   // ------------------------------------------------------------
   // about 60 apb accesses of 3 cycles plus reset with wide margin
   localparam int CYCLE_LIMIT     = 2000;
   // a no-wait-state slave answers in the first access cycle
   localparam int ACCESS_WAIT_MAX = 8;
   // sample a quarter period after the falling edge
   localparam int SAMPLE_DELAY    = 25;
   localparam int N_RETIRE        = 5;

   // warl rules for mepc word alignment and mtvec bit 1
   localparam logic [31:0] EXP_MEPC_MASK    = ~32'h0000_0003;
   localparam logic [31:0] EXP_MTVEC_MASK   = ~32'h0000_0002;
   // mie bit 3, mpie bit 7, mpp bits 12:11
   localparam logic [31:0] EXP_MSTATUS_MASK = 32'h0000_1888;
   // mpp = machine mode out of reset
   localparam logic [31:0] EXP_MSTATUS_RST  = 32'h0000_1800;

   logic              clk;
   logic              arst_n;
   logic              psel;
   logic              penable;
   logic              pwrite;
   logic [13:0]       paddr;
   logic [31:0]       pwdata;
   logic [31:0]       prdata;
   logic              pready;
   logic              pslverr;
   priv_mode_t        priv_mode;
   logic [63:0]       mtime;
   logic              instr_retired;

   integer seed;
   int     errors;
   int     checks;
   int     tests_run;
   int     cycle_count;

   tb_clock_gen clk_gen0 (
      .clk    (clk),
      .arst_n (arst_n)
   );

   csr_unit dut0 (
      .clk           (clk),
      .arst_n        (arst_n),
      .psel          (psel),
      .penable       (penable),
      .pwrite        (pwrite),
      .paddr         (paddr),
      .pwdata        (pwdata),
      .prdata        (prdata),
      .pready        (pready),
      .pslverr       (pslverr),
      .priv_mode     (priv_mode),
      .mtime         (mtime),
      .instr_retired (instr_retired)
   );

   // ------------------------------------------------------------
   // apb access and checks
   // ------------------------------------------------------------
   // setup then access until pready and return at a falling edge
   task automatic apb_access(input logic wr, input logic [11:0] num,
                             input logic [31:0] wdata,
                             output logic [31:0] rdata, output logic err);
      int waits;
      waits = 0;
      @(negedge clk);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = wr;
      paddr   = {num, 2'b00};
      pwdata  = wdata;
      @(negedge clk);
      penable = 1'b1;
      #(SAMPLE_DELAY);
      while (!pready && waits < ACCESS_WAIT_MAX)
      begin
         @(negedge clk);
         #(SAMPLE_DELAY);
         waits++;
      end
      if (!pready)
      begin
         $display("no pready within %0d cycles for csr 0x%03h", ACCESS_WAIT_MAX, num);
         errors++;
      end
      rdata = prdata;
      err   = pslverr;
      // write lands on the rising edge just passed
      @(negedge clk);
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic check_err(input logic [11:0] num, input logic got, input logic exp);
      checks++;
      if (got !== exp)
      begin
         $display("FAILED pslverr (csr 0x%03h): got 0x%h, expected 0x%h", num, got, exp);
         errors++;
      end
   endtask

   task automatic check_word(input logic [11:0] num, input logic [31:0] got,
                             input logic [31:0] exp);
      checks++;
      if (got !== exp)
      begin
         $display("FAILED prdata (csr 0x%03h): got 0x%08h, expected 0x%08h", num, got, exp);
         errors++;
      end
   endtask

   // a refused access must also return zero data
   task automatic csr_read(input logic [11:0] num, input logic exp_err,
                           output logic [31:0] got);
      logic err;
      apb_access(1'b0, num, 32'h0, got, err);
      check_err(num, err, exp_err);
      if (exp_err)
         check_word(num, got, 32'h0);
   endtask

   task automatic csr_write(input logic [11:0] num, input logic [31:0] data,
                            input logic exp_err);
      logic [31:0] rd;
      logic        err;
      apb_access(1'b1, num, data, rd, err);
      check_err(num, err, exp_err);
      if (exp_err)
         check_word(num, rd, 32'h0);
   endtask

   task automatic read_check(input logic [11:0] num, input logic [31:0] exp);
      logic [31:0] got;
      csr_read(num, 1'b0, got);
      check_word(num, got, exp);
   endtask

   task automatic pulse_retired(input int n);
      repeat (n)
      begin
         @(negedge clk);
         instr_retired = 1'b1;
         @(negedge clk);
         instr_retired = 1'b0;
      end
   endtask

   task automatic report_test(input string name, input int err_before);
      tests_run++;
      if (errors == err_before)
         $display("test %s: ok", name);
      else
         $display("test %s: %0d errors", name, errors - err_before);
   endtask

   // ------------------------------------------------------------
   // directed tests
   // ------------------------------------------------------------
   task automatic test_ident();
      int err_before;
      err_before = errors;
      read_check(CSR_MISA, MISA_VAL);
      read_check(CSR_MVENDORID, MVENDORID_VAL);
      read_check(CSR_MARCHID, MARCHID_VAL);
      read_check(CSR_MIMPID, MIMPID_VAL);
      read_check(CSR_MHARTID, MHARTID_VAL);
      // write to a read-only number is refused and the value kept
      csr_write(CSR_MVENDORID, 32'hDEAD_BEEF, 1'b1);
      read_check(CSR_MVENDORID, MVENDORID_VAL);
      report_test("identification", err_before);
   endtask

   task automatic test_trap_regs();
      int          err_before;
      logic [31:0] d;
      err_before = errors;
      read_check(CSR_MSTATUS, EXP_MSTATUS_RST);
      d = $random(seed);
      csr_write(CSR_MSCRATCH, d, 1'b0);
      read_check(CSR_MSCRATCH, d);
      d = $random(seed);
      csr_write(CSR_MCAUSE, d, 1'b0);
      read_check(CSR_MCAUSE, d);
      d = $random(seed);
      csr_write(CSR_MTVAL, d, 1'b0);
      read_check(CSR_MTVAL, d);
      d = $random(seed);
      csr_write(CSR_MIE, d, 1'b0);
      read_check(CSR_MIE, d);
      // warl fields
      d = $random(seed) | 32'h3;
      csr_write(CSR_MEPC, d, 1'b0);
      read_check(CSR_MEPC, d & EXP_MEPC_MASK);
      d = $random(seed) | 32'h2;
      csr_write(CSR_MTVEC, d, 1'b0);
      read_check(CSR_MTVEC, d & EXP_MTVEC_MASK);
      csr_write(CSR_MSTATUS, 32'hFFFF_FFFF, 1'b0);
      read_check(CSR_MSTATUS, EXP_MSTATUS_MASK);
      report_test("trap registers", err_before);
   endtask

   task automatic test_unknown();
      int          err_before;
      logic [31:0] d;
      logic [31:0] v;
      err_before = errors;
      d = $random(seed);
      csr_write(CSR_MSCRATCH, d, 1'b0);
      // sstatus, pmpcfg0, dcsr
      csr_read(12'h100, 1'b1, v);
      csr_write(12'h100, 32'hFFFF_FFFF, 1'b1);
      csr_read(12'h3A0, 1'b1, v);
      csr_write(12'h3A0, 32'hFFFF_FFFF, 1'b1);
      csr_read(12'h7B0, 1'b1, v);
      csr_write(12'h7B0, 32'hFFFF_FFFF, 1'b1);
      read_check(CSR_MSCRATCH, d);
      report_test("unknown numbers", err_before);
   endtask

   task automatic test_counters();
      int          err_before;
      logic [31:0] lo_c;
      logic [31:0] hi_c;
      logic [31:0] lo_r;
      logic [31:0] hi_r;
      logic [63:0] exp_r;
      logic [31:0] first;
      logic [31:0] second;
      err_before = errors;
      // keep the low half far from wrapping
      lo_c = $random(seed) & 32'h7FFF_FFFF;
      hi_c = $random(seed);
      lo_r = $random(seed);
      hi_r = $random(seed);
      // inhibit both counters
      csr_write(CSR_MCOUNTINHIBIT, 32'h0000_0005, 1'b0);
      csr_write(CSR_MCYCLE, lo_c, 1'b0);
      csr_write(CSR_MCYCLEH, hi_c, 1'b0);
      csr_write(CSR_MINSTRET, lo_r, 1'b0);
      csr_write(CSR_MINSTRETH, hi_r, 1'b0);
      pulse_retired(3);
      read_check(CSR_MCYCLE, lo_c);
      read_check(CSR_MCYCLEH, hi_c);
      read_check(CSR_MINSTRET, lo_r);
      read_check(CSR_MINSTRETH, hi_r);
      // counting again
      csr_write(CSR_MCOUNTINHIBIT, 32'h0, 1'b0);
      pulse_retired(N_RETIRE);
      exp_r = {hi_r, lo_r} + 64'(N_RETIRE);
      read_check(CSR_MINSTRET, exp_r[31:0]);
      read_check(CSR_MINSTRETH, exp_r[63:32]);
      csr_read(CSR_MCYCLE, 1'b0, first);
      csr_read(CSR_MCYCLE, 1'b0, second);
      checks++;
      if (second <= first)
      begin
         $display("FAILED prdata mcycle not increasing: first 0x%08h, second 0x%08h",
                  first, second);
         errors++;
      end
      report_test("counters", err_before);
   endtask

   // priv_mode changes happen at the falling edge each access ends on
   task automatic test_user_mode();
      int          err_before;
      logic [31:0] v;
      logic [31:0] ret_m;
      logic [31:0] keep;
      logic [63:0] tm;
      err_before = errors;
      keep = $random(seed);
      csr_write(CSR_MSCRATCH, keep, 1'b0);
      csr_write(CSR_MCOUNTEREN, 32'h0, 1'b0);
      priv_mode = U_MODE;
      csr_read(CSR_MSTATUS, 1'b1, v);
      csr_read(CSR_MSCRATCH, 1'b1, v);
      csr_write(CSR_MSCRATCH, 32'h1234_5678, 1'b1);
      csr_read(CSR_MCYCLE, 1'b1, v);
      csr_read(CSR_CYCLE, 1'b1, v);
      // the refused user write leaves mscratch alone
      priv_mode = M_MODE;
      read_check(CSR_MSCRATCH, keep);
      // mcounteren bit 0 opens cycle
      csr_write(CSR_MCOUNTEREN, 32'h1, 1'b0);
      priv_mode = U_MODE;
      csr_read(CSR_CYCLE, 1'b0, v);
      priv_mode = M_MODE;
      csr_write(CSR_MCOUNTEREN, 32'h0, 1'b0);
      priv_mode = U_MODE;
      csr_read(CSR_CYCLE, 1'b1, v);
      // time and instret with both counters frozen
      priv_mode = M_MODE;
      csr_write(CSR_MCOUNTEREN, 32'h7, 1'b0);
      csr_write(CSR_MCOUNTINHIBIT, 32'h5, 1'b0);
      csr_read(CSR_MINSTRET, 1'b0, ret_m);
      tm[31:0]  = $random(seed);
      tm[63:32] = $random(seed);
      mtime     = tm;
      priv_mode = U_MODE;
      read_check(CSR_TIME, tm[31:0]);
      read_check(CSR_TIMEH, tm[63:32]);
      read_check(CSR_INSTRET, ret_m);
      priv_mode = M_MODE;
      report_test("user mode gating", err_before);
   endtask

   // ------------------------------------------------------------
   // main sequence and watchdog
   // ------------------------------------------------------------
   initial
   begin
      seed          = 330;
      errors        = 0;
      checks        = 0;
      tests_run     = 0;
      psel          = 1'b0;
      penable       = 1'b0;
      pwrite        = 1'b0;
      paddr         = '0;
      pwdata        = '0;
      priv_mode     = M_MODE;
      mtime         = '0;
      instr_retired = 1'b0;
      @(posedge arst_n);
      @(negedge clk);
      test_ident();
      test_trap_regs();
      test_unknown();
      test_counters();
      test_user_mode();
      $display("summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
      if (errors == 0)
         $display("TB PASSED");
      else
         $display("TB FAILED");
      $finish;
   end

   initial
   begin
      cycle_count = 0;
      while (cycle_count < CYCLE_LIMIT)
      begin
         @(posedge clk);
         cycle_count++;
      end
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("TB FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== tb.f ====
src/csr_pkg.sv
src/csr_apb_slave.sv
src/csr_decode.sv
src/csr_machine_regs.sv
src/csr_counters.sv
src/csr_unit.sv
sim/tb_clock_gen.sv
sim/csr_unit_props.sv
sim/tb_csr_unit.sv

// ==== Makefile ====
# Verilator build and run of the CSR unit testbench

SRCS := $(shell cat tb.f)

all: run

obj_dir/Vtb_csr_unit: tb.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_csr_unit \
		-f tb.f -Mdir obj_dir -o Vtb_csr_unit

# the run passes only if the log holds the pass line
run: obj_dir/Vtb_csr_unit
	./obj_dir/Vtb_csr_unit | tee sim.log
	grep -q "^TB PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
